/* sim.f */
+incdir+include
verilog/mem_bus_pkg.sv
verilog/lsu_pkg.sv
verilog/instr_fetch.sv
verilog/lsu.sv
verilog/bus_arbiter.sv
verilog/sram_model.sv
verilog/fetch_mem_top.sv
verif/tb_fetch_mem_top.sv

/* Bender.yml */
package:
  name: fetch_mem

export_include_dirs:
  - include

sources:
  - files:
      - verilog/mem_bus_pkg.sv
      - verilog/lsu_pkg.sv
      - verilog/instr_fetch.sv
      - verilog/lsu.sv
      - verilog/bus_arbiter.sv
      - verilog/sram_model.sv
      - verilog/fetch_mem_top.sv
  - target: test
    files:
      - verif/tb_fetch_mem_top.sv

/* verif/tb_fetch_mem_top.sv */
// --------------------
// Testbench for the fetch_mem subsystem.
// Clock, stimulus tasks, memory reference model, checker and watchdog.
// --------------------
`timescale 1ns/1ps
`include "fetch_mem_config.svh"

module tb_fetch_mem_top import lsu_pkg::*; ();

  localparam int unsigned MemBytes   = `FM_MEM_WORDS * 4;
  localparam int unsigned IdxW       = $clog2(`FM_MEM_WORDS);
  localparam int unsigned NRand      = 40;
  localparam int unsigned NFetchRuns = 4;
  localparam int unsigned NFetchLen  = 8;
  // Operations over all tests, each allowed 40 cycles.
  localparam int unsigned NOps = `FM_MEM_WORDS + 2 * 64 + 28 + 11 + 4 + NRand
                                 + NFetchRuns * NFetchLen;
  localparam int unsigned TimeoutCycles = NOps * 40 + 200;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req_i;
  logic                  branch_i;
  logic [`FM_ADDR_W-1:0] branch_addr_i;
  logic                  ready_i;
  logic                  valid_o;
  logic [`FM_DATA_W-1:0] rdata_o;
  logic [`FM_ADDR_W-1:0] addr_o;
  logic                  err_o;
  logic                  busy_o;
  logic                  cmd_valid_i;
  logic                  cmd_ready_o;
  logic                  cmd_we_i;
  lsu_size_e             cmd_size_i;
  logic [`FM_ADDR_W-1:0] cmd_addr_i;
  logic [`FM_DATA_W-1:0] cmd_wdata_i;
  logic                  rsp_valid_o;
  logic [`FM_DATA_W-1:0] rsp_rdata_o;
  logic                  rsp_err_o;

  // Reference copy of memory, updated when a store is accepted.
  logic [`FM_DATA_W-1:0] mem_model [`FM_MEM_WORDS];
  // Expected {err, data} per LSU command, expected address per fetch.
  logic [`FM_DATA_W:0]   lsu_exp_q [$];
  logic [`FM_ADDR_W-1:0] fetch_exp_q [$];
  int unsigned           lsu_done;
  int unsigned           fetch_done;
  int unsigned           checks;
  int unsigned           errors;

  fetch_mem_top fetch_mem_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Off its natural boundary, an illegal size, or beyond the last word.
  function automatic logic access_bad(lsu_size_e size, logic [`FM_ADDR_W-1:0] addr);
    logic bad;
    case (size)
      SIZE_BYTE: bad = 1'b0;
      SIZE_HALF: bad = addr[0];
      SIZE_WORD: bad = (addr[1:0] != 2'b00);
      default:   bad = 1'b1;
    endcase
    return bad || (addr >= MemBytes);
  endfunction

  // Expected {err, data} of a load, lanes zero-extended.
  function automatic logic [`FM_DATA_W:0] ref_load(lsu_size_e size,
                                                   logic [`FM_ADDR_W-1:0] addr);
    logic [`FM_DATA_W-1:0] word;
    logic [`FM_DATA_W:0]   res;
    int unsigned           sh;
    sh = addr[1:0] * 8;
    if (access_bad(size, addr)) begin
      res = {1'b1, `FM_DATA_W'(0)};
    end else begin
      word = mem_model[addr[IdxW+1:2]];
      case (size)
        SIZE_BYTE: res = {1'b0, `FM_DATA_W'(word[sh +: 8])};
        SIZE_HALF: res = {1'b0, `FM_DATA_W'(word[sh +: 16])};
        default:   res = {1'b0, word};
      endcase
    end
    return res;
  endfunction

  // Merge a legal store into the model.
  function automatic void model_store(lsu_size_e size, logic [`FM_ADDR_W-1:0] addr,
                                      logic [`FM_DATA_W-1:0] data);
    int unsigned sh;
    sh = addr[1:0] * 8;
    case (size)
      SIZE_BYTE: mem_model[addr[IdxW+1:2]][sh +: 8]  = data[7:0];
      SIZE_HALF: mem_model[addr[IdxW+1:2]][sh +: 16] = data[15:0];
      default:   mem_model[addr[IdxW+1:2]]           = data;
    endcase
  endfunction

  // Initial memory contents, distinct for every address.
  function automatic logic [`FM_DATA_W-1:0] fill_word(logic [`FM_ADDR_W-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] expd, logic [31:0] got);
    errors++;
    $display("MISMATCH %s: expected %0h, got %0h at %0t", name, expd, got, $time);
  endtask

  task automatic print_test_result(string name, int unsigned err_mark);
    $display("test %-12s done, %0d errors", name, errors - err_mark);
  endtask

  // One LSU command, from handshake to response. Starts and ends on a falling edge.
  task automatic lsu_op(logic we, lsu_size_e size, logic [`FM_ADDR_W-1:0] addr,
                        logic [`FM_DATA_W-1:0] wdata);
    logic [`FM_DATA_W:0] expv;
    int unsigned         target;
    target      = lsu_done + 1;
    cmd_valid_i = 1'b1;
    cmd_we_i    = we;
    cmd_size_i  = size;
    cmd_addr_i  = addr;
    cmd_wdata_i = wdata;
    do @(posedge clk_i); while (!cmd_ready_o);
    // Result follows memory as it stands at acceptance.
    expv = ref_load(size, addr);
    if (we) begin
      expv[`FM_DATA_W-1:0] = '0;
      if (!expv[`FM_DATA_W]) model_store(size, addr, wdata);
    end
    lsu_exp_q.push_back(expv);
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    while (lsu_done < target) @(negedge clk_i);
  endtask

  // Branch to start, then sequential fetches, one in flight at a time.
  task automatic fetch_seq(logic [`FM_ADDR_W-1:0] start, int unsigned n);
    int unsigned target;
    target = fetch_done;
    for (int unsigned k = 0; k < n; k++) begin
      req_i = 1'b1;
      if (k == 0) begin
        branch_i      = 1'b1;
        branch_addr_i = start;
      end else begin
        ready_i = 1'b1;
      end
      fetch_exp_q.push_back(start + 4 * k);
      target++;
      @(negedge clk_i);
      branch_i = 1'b0;
      ready_i  = 1'b0;
      while (fetch_done < target) @(negedge clk_i);
    end
    req_i = 1'b0;
  endtask

  // A second branch lands while the first fetch is on the bus.
  task automatic branch_in_flight(logic [`FM_ADDR_W-1:0] old_addr,
                                  logic [`FM_ADDR_W-1:0] new_addr);
    int unsigned target;
    target        = fetch_done + 1;
    req_i         = 1'b1;
    branch_i      = 1'b1;
    branch_addr_i = old_addr;
    @(negedge clk_i);
    checks++;
    if (!busy_o) begin
      errors++;
      $display("ERROR: fetch of %h was not outstanding when the branch came", old_addr);
    end
    // Only the new target may answer.
    branch_addr_i = new_addr;
    fetch_exp_q.push_back(new_addr);
    @(negedge clk_i);
    branch_i = 1'b0;
    while (fetch_done < target) @(negedge clk_i);
    req_i = 1'b0;
  endtask

  // Checker. Outputs are settled by the rising edge.
  always @(posedge clk_i) begin
    logic [`FM_DATA_W:0]   expv;
    logic [`FM_ADDR_W-1:0] ea;
    if (rst_ni) begin
      if (rsp_valid_o || rsp_err_o) begin
        checks++;
        if (lsu_exp_q.size() == 0) begin
          errors++;
          $display("ERROR: LSU response with no command outstanding at %0t", $time);
        end else begin
          expv = lsu_exp_q.pop_front();
          if (rsp_err_o !== expv[`FM_DATA_W]) begin
            report_mismatch("rsp_err_o", expv[`FM_DATA_W], rsp_err_o);
          end else if (!expv[`FM_DATA_W] && rsp_rdata_o !== expv[`FM_DATA_W-1:0]) begin
            report_mismatch("rsp_rdata_o", expv[`FM_DATA_W-1:0], rsp_rdata_o);
          end
        end
        lsu_done++;
      end
      if (valid_o || err_o) begin
        checks++;
        if (fetch_exp_q.size() == 0) begin
          errors++;
          $display("ERROR: fetch response with no fetch expected at %0t", $time);
        end else begin
          ea   = fetch_exp_q.pop_front();
          expv = ref_load(SIZE_WORD, ea);
          if (addr_o !== ea) begin
            report_mismatch("addr_o", ea, addr_o);
          end else if (err_o !== expv[`FM_DATA_W]) begin
            report_mismatch("err_o", expv[`FM_DATA_W], err_o);
          end else if (!expv[`FM_DATA_W] && rdata_o !== expv[`FM_DATA_W-1:0]) begin
            report_mismatch("rdata_o", expv[`FM_DATA_W-1:0], rdata_o);
          end
        end
        fetch_done++;
      end
    end
  end

  // Watchdog.
  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("ERROR: timeout, run still going after %0d cycles", TimeoutCycles);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    logic [`FM_ADDR_W-1:0] addrs [64];
    logic [`FM_ADDR_W-1:0] base;
    logic                  r_we [NRand];
    lsu_size_e             r_size [NRand];
    logic [`FM_ADDR_W-1:0] r_addr [NRand];
    logic [`FM_DATA_W-1:0] r_data [NRand];
    logic [`FM_ADDR_W-1:0] f_start [NFetchRuns];
    int unsigned           err_mark;
    void'($urandom(17));
    rst_ni        = 1'b0;
    req_i         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    ready_i       = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_we_i      = 1'b0;
    cmd_size_i    = SIZE_BYTE;
    cmd_addr_i    = '0;
    cmd_wdata_i   = '0;
    lsu_done      = 0;
    fetch_done    = 0;
    checks        = 0;
    errors        = 0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    // Outputs quiet after reset, command port opens a cycle later.
    err_mark = errors;
    checks += 5;
    if (valid_o !== 1'b0) report_mismatch("valid_o", 0, valid_o);
    if (busy_o !== 1'b0) report_mismatch("busy_o", 0, busy_o);
    if (rsp_valid_o !== 1'b0) report_mismatch("rsp_valid_o", 0, rsp_valid_o);
    if (cmd_ready_o !== 1'b0) report_mismatch("cmd_ready_o", 0, cmd_ready_o);
    @(negedge clk_i);
    if (cmd_ready_o !== 1'b1) report_mismatch("cmd_ready_o", 1, cmd_ready_o);
    print_test_result("reset", err_mark);

    // Fill all of memory, then random word stores and loads.
    err_mark = errors;
    for (int unsigned w = 0; w < `FM_MEM_WORDS; w++) begin
      lsu_op(1'b1, SIZE_WORD, 4 * w, fill_word(4 * w));
    end
    for (int i = 0; i < 64; i++) begin
      addrs[i] = 4 * $urandom_range(0, `FM_MEM_WORDS - 1);
      lsu_op(1'b1, SIZE_WORD, addrs[i], $urandom);
    end
    for (int i = 0; i < 64; i++) lsu_op(1'b0, SIZE_WORD, addrs[i], '0);
    print_test_result("word", err_mark);

    // Every lane offset for each size; odd ones misalign halves and words.
    err_mark = errors;
    base     = 32'h300;
    for (int unsigned off = 0; off < 4; off++) begin
      lsu_op(1'b1, SIZE_BYTE, base + off, $urandom);
      lsu_op(1'b0, SIZE_BYTE, base + off, '0);
      lsu_op(1'b1, SIZE_HALF, base + 4 + off, $urandom);
      lsu_op(1'b0, SIZE_HALF, base + 4 + off, '0);
      lsu_op(1'b1, SIZE_WORD, base + 8 + off, $urandom);
      lsu_op(1'b0, SIZE_WORD, base + 8 + off, '0);
    end
    lsu_op(1'b0, SIZE_WORD, base, '0);
    lsu_op(1'b0, SIZE_WORD, MemBytes, '0);
    lsu_op(1'b1, SIZE_BYTE, MemBytes + 5, 32'h5a);
    lsu_op(1'b0, lsu_size_e'(2'b11), base, '0);
    print_test_result("byte/half", err_mark);

    // Sequential fetches, the second run crosses the end of memory.
    err_mark = errors;
    fetch_seq(32'h100, 6);
    fetch_seq(MemBytes - 12, 5);
    print_test_result("fetch", err_mark);

    err_mark = errors;
    branch_in_flight(32'h40, 32'h200);
    branch_in_flight(MemBytes + 32'h40, 32'h80);
    print_test_result("branch", err_mark);

    // LSU in the lower half, fetches read the upper half.
    err_mark = errors;
    for (int i = 0; i < NRand; i++) begin
      r_we[i]   = $urandom_range(0, 1);
      r_size[i] = lsu_size_e'($urandom_range(0, 2));
      r_addr[i] = $urandom_range(0, MemBytes / 2 - 1);
      r_data[i] = $urandom;
    end
    for (int r = 0; r < NFetchRuns; r++) begin
      f_start[r] = MemBytes / 2 + 4 * $urandom_range(0, `FM_MEM_WORDS / 2 - NFetchLen);
    end
    fork
      begin
        for (int i = 0; i < NRand; i++) lsu_op(r_we[i], r_size[i], r_addr[i], r_data[i]);
      end
      begin
        for (int r = 0; r < NFetchRuns; r++) fetch_seq(f_start[r], NFetchLen);
      end
    join
    print_test_result("concurrent", err_mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/fetch_mem_top.sv */
// --------------------
// Top of the fetch_mem subsystem.
// Fetch unit and LSU share one memory through the arbiter.
// --------------------
`timescale 1ns/1ps
`include "fetch_mem_config.svh"

module fetch_mem_top import mem_bus_pkg::*, lsu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  branch_i,
  input  logic [`FM_ADDR_W-1:0] branch_addr_i,
  input  logic                  ready_i,
  output logic                  valid_o,
  output logic [`FM_DATA_W-1:0] rdata_o,
  output logic [`FM_ADDR_W-1:0] addr_o,
  output logic                  err_o,
  output logic                  busy_o,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  logic                  cmd_we_i,
  input  lsu_size_e             cmd_size_i,
  input  logic [`FM_ADDR_W-1:0] cmd_addr_i,
  input  logic [`FM_DATA_W-1:0] cmd_wdata_i,
  output logic                  rsp_valid_o,
  output logic [`FM_DATA_W-1:0] rsp_rdata_o,
  output logic                  rsp_err_o
);

  // Master bus wires, one slot per master.
  logic [1:0]              m_req, m_gnt, m_rvalid, m_err;
  logic [`FM_ADDR_W-1:0]   m_addr  [2];
  logic [`FM_DATA_W-1:0]   m_rdata [2];
  logic                    d_we;
  logic [`FM_DATA_W/8-1:0] d_be;
  logic [`FM_DATA_W-1:0]   d_wdata;

  // Memory bus wires.
  logic                    s_req, s_gnt, s_we, s_rvalid, s_err;
  logic [`FM_ADDR_W-1:0]   s_addr;
  logic [`FM_DATA_W/8-1:0] s_be;
  logic [`FM_DATA_W-1:0]   s_wdata, s_rdata;

  instr_fetch instr_fetch_i (
    .clk_i, .rst_ni, .req_i, .branch_i, .branch_addr_i, .ready_i,
    .valid_o, .rdata_o, .addr_o, .err_o, .busy_o,
    .instr_req_o   (m_req[SRC_FETCH]),
    .instr_gnt_i   (m_gnt[SRC_FETCH]),
    .instr_addr_o  (m_addr[SRC_FETCH]),
    .instr_rdata_i (m_rdata[SRC_FETCH]),
    .instr_rvalid_i(m_rvalid[SRC_FETCH]),
    .instr_err_i   (m_err[SRC_FETCH])
  );

  lsu lsu_i (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_ready_o, .cmd_we_i, .cmd_size_i,
    .cmd_addr_i, .cmd_wdata_i, .rsp_valid_o, .rsp_rdata_o, .rsp_err_o,
    .data_req_o   (m_req[SRC_LSU]),
    .data_gnt_i   (m_gnt[SRC_LSU]),
    .data_addr_o  (m_addr[SRC_LSU]),
    .data_we_o    (d_we),
    .data_be_o    (d_be),
    .data_wdata_o (d_wdata),
    .data_rdata_i (m_rdata[SRC_LSU]),
    .data_rvalid_i(m_rvalid[SRC_LSU]),
    .data_err_i   (m_err[SRC_LSU])
  );

  // Fetches are full-word reads.
  bus_arbiter bus_arbiter_i (
    .clk_i, .rst_ni,
    .f_req_i(m_req[SRC_FETCH]), .f_addr_i(m_addr[SRC_FETCH]), .f_we_i(1'b0),
    .f_be_i('1), .f_wdata_i('0), .f_gnt_o(m_gnt[SRC_FETCH]),
    .f_rdata_o(m_rdata[SRC_FETCH]), .f_rvalid_o(m_rvalid[SRC_FETCH]),
    .f_err_o(m_err[SRC_FETCH]),
    .d_req_i(m_req[SRC_LSU]), .d_addr_i(m_addr[SRC_LSU]), .d_we_i(d_we),
    .d_be_i(d_be), .d_wdata_i(d_wdata), .d_gnt_o(m_gnt[SRC_LSU]),
    .d_rdata_o(m_rdata[SRC_LSU]), .d_rvalid_o(m_rvalid[SRC_LSU]),
    .d_err_o(m_err[SRC_LSU]),
    .mem_req_o(s_req), .mem_addr_o(s_addr), .mem_we_o(s_we), .mem_be_o(s_be),
    .mem_wdata_o(s_wdata), .mem_gnt_i(s_gnt), .mem_rdata_i(s_rdata),
    .mem_rvalid_i(s_rvalid), .mem_err_i(s_err)
  );

  sram_model sram_model_i (
    .clk_i, .rst_ni,
    .req_i   (s_req),
    .gnt_o   (s_gnt),
    .addr_i  (s_addr),
    .we_i    (s_we),
    .be_i    (s_be),
    .wdata_i (s_wdata),
    .rdata_o (s_rdata),
    .rvalid_o(s_rvalid),
    .err_o   (s_err)
  );

endmodule

/* verilog/sram_model.sv */
// --------------------
// Word memory, byte-enabled writes.
// One-cycle response, error beyond the last word.
// --------------------
`timescale 1ns/1ps
`include "fetch_mem_config.svh"

module sram_model (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  output logic                    gnt_o,
  input  logic [`FM_ADDR_W-1:0]   addr_i,
  input  logic                    we_i,
  input  logic [`FM_DATA_W/8-1:0] be_i,
  input  logic [`FM_DATA_W-1:0]   wdata_i,
  output logic [`FM_DATA_W-1:0]   rdata_o,
  output logic                    rvalid_o,
  output logic                    err_o
);

  localparam int unsigned IdxW = $clog2(`FM_MEM_WORDS);

  logic [`FM_DATA_W-1:0] mem_q [`FM_MEM_WORDS];
  logic [IdxW-1:0]       idx;
  logic                  in_range;

  // Never stalls.
  assign gnt_o    = req_i;
  assign idx      = addr_i[IdxW+1:2];
  assign in_range = (addr_i[`FM_ADDR_W-1:2] < `FM_MEM_WORDS);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
    end else begin
      rvalid_o <= req_i & in_range;
      err_o    <= req_i & ~in_range;
    end
  end

  // Out-of-range writes leave memory untouched.
  always_ff @(posedge clk_i) begin
    if (req_i && in_range) begin
      rdata_o <= mem_q[idx];
      if (we_i) begin
        for (int b = 0; b < `FM_DATA_W / 8; b++) begin
          if (be_i[b]) mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Address and direction of a request must be known.
  a_req_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown({addr_i, we_i}));

endmodule

/* verilog/bus_arbiter.sv */
// --------------------
// Round-robin arbiter for two masters.
// One outstanding transaction, response routed to its owner.
// --------------------
`timescale 1ns/1ps
`include "fetch_mem_config.svh"

module bus_arbiter import mem_bus_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    f_req_i,
  input  logic [`FM_ADDR_W-1:0]   f_addr_i,
  input  logic                    f_we_i,
  input  logic [`FM_DATA_W/8-1:0] f_be_i,
  input  logic [`FM_DATA_W-1:0]   f_wdata_i,
  output logic                    f_gnt_o,
  output logic [`FM_DATA_W-1:0]   f_rdata_o,
  output logic                    f_rvalid_o,
  output logic                    f_err_o,
  input  logic                    d_req_i,
  input  logic [`FM_ADDR_W-1:0]   d_addr_i,
  input  logic                    d_we_i,
  input  logic [`FM_DATA_W/8-1:0] d_be_i,
  input  logic [`FM_DATA_W-1:0]   d_wdata_i,
  output logic                    d_gnt_o,
  output logic [`FM_DATA_W-1:0]   d_rdata_o,
  output logic                    d_rvalid_o,
  output logic                    d_err_o,
  output logic                    mem_req_o,
  output logic [`FM_ADDR_W-1:0]   mem_addr_o,
  output logic                    mem_we_o,
  output logic [`FM_DATA_W/8-1:0] mem_be_o,
  output logic [`FM_DATA_W-1:0]   mem_wdata_o,
  input  logic                    mem_gnt_i,
  input  logic [`FM_DATA_W-1:0]   mem_rdata_i,
  input  logic                    mem_rvalid_i,
  input  logic                    mem_err_i
);

  logic     busy_q;
  bus_src_e owner_q;
  bus_src_e last_q;
  bus_src_e pick;
  logic     grant;
  logic     resp;

  // With both requesting, the master that lost last time goes first.
  always_comb begin
    pick = SRC_FETCH;
    if (f_req_i && d_req_i) begin
      pick = src_other(last_q);
    end else if (d_req_i) begin
      pick = SRC_LSU;
    end
  end

  // No new request reaches memory while a response is pending.
  assign mem_req_o   = ~busy_q & (f_req_i | d_req_i);
  assign mem_addr_o  = (pick == SRC_FETCH) ? f_addr_i : d_addr_i;
  assign mem_we_o    = (pick == SRC_FETCH) ? f_we_i : d_we_i;
  assign mem_be_o    = (pick == SRC_FETCH) ? f_be_i : d_be_i;
  assign mem_wdata_o = (pick == SRC_FETCH) ? f_wdata_i : d_wdata_i;

  assign grant   = mem_req_o & mem_gnt_i;
  assign f_gnt_o = grant & (pick == SRC_FETCH);
  assign d_gnt_o = grant & (pick == SRC_LSU);
  assign resp    = mem_rvalid_i | mem_err_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      owner_q <= SRC_FETCH;
      last_q  <= SRC_LSU;
    end else if (grant) begin
      busy_q  <= 1'b1;
      owner_q <= pick;
      last_q  <= pick;
    end else if (resp) begin
      busy_q <= 1'b0;
    end
  end

  // The response goes to the owner only.
  assign f_rvalid_o = mem_rvalid_i & busy_q & (owner_q == SRC_FETCH);
  assign f_err_o    = mem_err_i & busy_q & (owner_q == SRC_FETCH);
  assign d_rvalid_o = mem_rvalid_i & busy_q & (owner_q == SRC_LSU);
  assign d_err_o    = mem_err_i & busy_q & (owner_q == SRC_LSU);
  assign f_rdata_o  = mem_rdata_i;
  assign d_rdata_o  = mem_rdata_i;

  // A master keeps its request up until it is granted.
  a_f_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    f_req_i && !f_gnt_o |=> f_req_i);

  a_d_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_req_i && !d_gnt_o |=> d_req_i);

  // Memory answers only transactions that were granted.
  a_resp_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp |-> busy_q);

endmodule

/* verilog/lsu.sv */
// --------------------
// Load/store unit.
// Alignment check, byte enables and zero-extended loads.
// --------------------
`timescale 1ns/1ps
`include "fetch_mem_config.svh"

module lsu import lsu_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  input  logic                    cmd_we_i,
  input  lsu_size_e               cmd_size_i,
  input  logic [`FM_ADDR_W-1:0]   cmd_addr_i,
  input  logic [`FM_DATA_W-1:0]   cmd_wdata_i,
  output logic                    rsp_valid_o,
  output logic [`FM_DATA_W-1:0]   rsp_rdata_o,
  output logic                    rsp_err_o,
  output logic                    data_req_o,
  input  logic                    data_gnt_i,
  output logic [`FM_ADDR_W-1:0]   data_addr_o,
  output logic                    data_we_o,
  output logic [`FM_DATA_W/8-1:0] data_be_o,
  output logic [`FM_DATA_W-1:0]   data_wdata_o,
  input  logic [`FM_DATA_W-1:0]   data_rdata_i,
  input  logic                    data_rvalid_i,
  input  logic                    data_err_i
);

  localparam int unsigned BeW = `FM_DATA_W / 8;

  typedef enum logic [2:0] {S_INIT, S_IDLE, S_REQ, S_WAIT, S_ERR} lsu_state_e;

  lsu_state_e            state_q, state_d;
  logic                  we_q;
  lsu_size_e             size_q;
  logic [`FM_ADDR_W-1:0] addr_q;
  logic [`FM_DATA_W-1:0] wdata_q;
  logic                  cmd_fire;
  logic [`FM_DATA_W-1:0] rdata_shift;

  // Ready only in idle, which is entered one cycle after reset.
  assign cmd_ready_o = (state_q == S_IDLE);
  assign cmd_fire    = cmd_valid_i & cmd_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_INIT: state_d = S_IDLE;
      S_IDLE: begin
        // Misaligned or illegal commands skip the bus.
        if (cmd_fire) begin
          state_d = lsu_aligned(cmd_size_i, cmd_addr_i[1:0]) ? S_REQ : S_ERR;
        end
      end
      S_REQ:  if (data_gnt_i) state_d = S_WAIT;
      S_WAIT: if (data_rvalid_i || data_err_i) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_INIT;
    end else begin
      state_q <= state_d;
    end
  end

  // Command capture.
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      we_q    <= cmd_we_i;
      size_q  <= cmd_size_i;
      addr_q  <= cmd_addr_i;
      wdata_q <= cmd_wdata_i;
    end
  end

  assign data_req_o  = (state_q == S_REQ);
  assign data_we_o   = we_q;
  assign data_addr_o = {addr_q[`FM_ADDR_W-1:2], 2'b00};

  // Lanes selected by size and offset, store data copied into every lane.
  always_comb begin
    case (size_q)
      SIZE_BYTE: begin
        data_be_o    = BeW'(1) << addr_q[1:0];
        data_wdata_o = {(`FM_DATA_W/8){wdata_q[7:0]}};
      end
      SIZE_HALF: begin
        data_be_o    = BeW'(3) << addr_q[1:0];
        data_wdata_o = {(`FM_DATA_W/16){wdata_q[15:0]}};
      end
      SIZE_WORD: begin
        data_be_o    = '1;
        data_wdata_o = wdata_q;
      end
      default: begin
        data_be_o    = '0;
        data_wdata_o = wdata_q;
      end
    endcase
  end

  // Load data moved down to lane 0, then zero-extended.
  assign rdata_shift = data_rdata_i >> {addr_q[1:0], 3'b000};

  always_comb begin
    if (we_q) begin
      rsp_rdata_o = '0;
    end else begin
      case (size_q)
        SIZE_BYTE: rsp_rdata_o = `FM_DATA_W'(rdata_shift[7:0]);
        SIZE_HALF: rsp_rdata_o = `FM_DATA_W'(rdata_shift[15:0]);
        default:   rsp_rdata_o = rdata_shift;
      endcase
    end
  end

  assign rsp_valid_o = (state_q == S_WAIT) & data_rvalid_i;
  assign rsp_err_o   = (state_q == S_ERR) | ((state_q == S_WAIT) & data_err_i);

  // Only aligned, legal commands reach the bus.
  a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> data_be_o != '0);

endmodule

/* verilog/instr_fetch.sv */
// --------------------
// Non-prefetching instruction fetch unit.
// One bus request per instruction, branches held mid-transaction.
// --------------------
`timescale 1ns/1ps
`include "fetch_mem_config.svh"

module instr_fetch (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  branch_i,
  input  logic [`FM_ADDR_W-1:0] branch_addr_i,
  input  logic                  ready_i,
  output logic                  valid_o,
  output logic [`FM_DATA_W-1:0] rdata_o,
  output logic [`FM_ADDR_W-1:0] addr_o,
  output logic                  err_o,
  output logic                  busy_o,
  output logic                  instr_req_o,
  input  logic                  instr_gnt_i,
  output logic [`FM_ADDR_W-1:0] instr_addr_o,
  input  logic [`FM_DATA_W-1:0] instr_rdata_i,
  input  logic                  instr_rvalid_i,
  input  logic                  instr_err_i
);

  logic                  ongoing_q;
  logic                  branch_pend_q;
  logic                  req_q;
  logic [`FM_ADDR_W-1:0] addr_q;
  logic                  branch_now;
  logic                  resp;

  // Branch from the core while a transaction is in flight.
  assign branch_now = ongoing_q & req_i & branch_i;
  assign resp       = instr_rvalid_i | instr_err_i;

  always_comb begin
    if (!ongoing_q) begin
      if (branch_pend_q) begin
        // Issue the target stored during the last transaction.
        instr_req_o  = req_i;
        instr_addr_o = addr_q;
      end else begin
        // New fetches go onto the bus in the same cycle.
        instr_req_o  = req_i & (ready_i | branch_i);
        instr_addr_o = branch_i ? branch_addr_i : addr_q + `FM_ADDR_W'(4);
      end
    end else begin
      // Bus stalled, so keep the request up from the registers.
      instr_req_o  = req_q;
      instr_addr_o = addr_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ongoing_q     <= 1'b0;
      branch_pend_q <= 1'b0;
      req_q         <= 1'b0;
      addr_q        <= '0;
    end else if (!ongoing_q) begin
      branch_pend_q <= 1'b0;
      if (instr_req_o) begin
        ongoing_q <= 1'b1;
        req_q     <= ~instr_gnt_i;
        addr_q    <= instr_addr_o;
      end
    end else begin
      // Hold a branch until the bus is free again.
      if (branch_now) begin
        branch_pend_q <= 1'b1;
        addr_q        <= branch_addr_i;
      end
      if (instr_gnt_i) begin
        req_q <= 1'b0;
      end
      if (resp) begin
        ongoing_q <= 1'b0;
      end
    end
  end

  // Responses to a fetch overtaken by a branch are dropped.
  assign valid_o = instr_rvalid_i & ~branch_pend_q & ~branch_now;
  assign err_o   = instr_err_i & ~branch_pend_q & ~branch_now;
  assign rdata_o = instr_rdata_i;
  assign addr_o  = addr_q;
  assign busy_o  = ongoing_q;

  // Once granted, no further request until the response returns.
  a_no_req_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && instr_gnt_i |=> !instr_req_o until_with resp);

endmodule

/* verilog/lsu_pkg.sv */
// --------------------
// Load/store operation types.
// Access size and alignment rule.
// --------------------
package lsu_pkg;

  // Access size of a load or store.
  // Encoding 2'b11 is not a legal size and is rejected.
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Alignment check on the two low address bits.
  // Halfwords must be even, words a multiple of 4, illegal sizes never pass.
  function automatic logic lsu_aligned(lsu_size_e size, logic [1:0] offs);
    logic ok;
    case (size)
      SIZE_BYTE: ok = 1'b1;
      SIZE_HALF: ok = ~offs[0];
      SIZE_WORD: ok = (offs == 2'b00);
      default:   ok = 1'b0;
    endcase
    return ok;
  endfunction

endpackage

/* verilog/mem_bus_pkg.sv */
// --------------------
// Bus-side types.
// Master identity for arbitration and routing.
// --------------------
package mem_bus_pkg;

  // Identity of a master on the shared memory bus.
  // One bit, so it can index a two-slot array directly.
  typedef enum logic {
    SRC_FETCH = 1'b0,
    SRC_LSU   = 1'b1
  } bus_src_e;

  // The other of the two masters.
  // Round-robin gives priority to the master that did not win last.
  function automatic bus_src_e src_other(bus_src_e src);
    bus_src_e res;
    res = (src == SRC_FETCH) ? SRC_LSU : SRC_FETCH;
    return res;
  endfunction

endpackage

/* include/fetch_mem_config.svh */
// --------------------
// Width and depth macros for the fetch_mem subsystem.
// Shared by all RTL blocks and the testbench.
// --------------------
`ifndef FETCH_MEM_CONFIG_SVH
`define FETCH_MEM_CONFIG_SVH

// Byte address width of both master buses and the memory bus.
`define FM_ADDR_W 32

// Data word width, a multiple of 8 bits.
`define FM_DATA_W 32

// Memory depth in words.
// Byte addresses from FM_MEM_WORDS*4 upwards answer with an error.
`define FM_MEM_WORDS 256

`endif
